// ==== hdl/uberclock_macros.svh ====
`ifndef UBERCLOCK_MACROS_SVH
`define UBERCLOCK_MACROS_SVH

// ---------------------------------------------------------------------------
// sample path widths
// ---------------------------------------------------------------------------
`define ADC_W          12      // adc and internal sample width
`define PHASE_W        24      // nco phase accumulator, full turn = 2^24

// cordic rotator
`define CORDIC_STAGES  14      // micro-rotation count
`define CORDIC_WW      16      // working width incl guard and fraction bits

// dac side
`define DAC_W          14      // dac word width
`define DAC_MID        8192    // mid-scale code, offset binary zero

// ---------------------------------------------------------------------------
// high-speed capture memory
// ---------------------------------------------------------------------------
`define CAP_DEPTH      512     // samples per capture
`define CAP_AW         9       // log2 of depth

`endif

// ==== hdl/dsp_pkg.sv ====
`include "uberclock_macros.svh"

package dsp_pkg;

    // two's complement sample, used on every internal path
    typedef logic signed [`ADC_W-1:0]   sample_t;

    // nco phase and increment, wraps mod 2^PHASE_W
    typedef logic        [`PHASE_W-1:0] phase_t;

    typedef logic        [`DAC_W-1:0]   dac_word_t;   // offset binary at the pin

    // capture memory word and readback index
    typedef logic signed [15:0]         cap_word_t;   // sample sign-extended
    typedef logic        [`CAP_AW-1:0]  cap_addr_t;

endpackage

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    // dac source select, codes as seen by the cpu
    // anything not listed drives zero (mid-scale at the pin)
    typedef enum logic [3:0] {
        SEL_NCO  = 4'd10,
        SEL_ADC0 = 4'd11,
        SEL_ADC1 = 4'd12
    } dac_sel_e;

    // high-speed debug tap select, code 3 falls back to nco
    typedef enum logic [1:0] {
        HS_ADC0 = 2'd0,
        HS_ADC1 = 2'd1,
        HS_NCO  = 2'd2
    } hs_sel_e;

    typedef enum logic [1:0] {
        CAP_IDLE,           // waiting for arm
        CAP_RUN,            // writing one sample per clock
        CAP_DONE            // buffer full, readback valid
    } cap_state_e;

endpackage

// ==== hdl/cordic_rotator.sv ====
`include "uberclock_macros.svh"

module cordic_rotator (
    input  logic             sys_clk,
    input  logic             rst,
    input  dsp_pkg::sample_t i_mag,     // vector length, rotated from (mag, 0)
    input  dsp_pkg::phase_t  i_phase,   // 2^PHASE_W per turn
    output dsp_pkg::sample_t o_cos
);
    import dsp_pkg::*;

    localparam int WW       = `CORDIC_WW;
    localparam int NS       = `CORDIC_STAGES;
    localparam int FRAC     = WW - `ADC_W - 2;            // 2 top bits for cordic gain
    localparam int SHIFT    = 16 + FRAC;                  // q16 gain + fraction bits
    localparam int RND_HALF = 1 << (SHIFT - 1);
    localparam int SAT_MAX  = (1 << (`ADC_W - 1)) - 1;
    localparam int SAT_MIN  = -(1 << (`ADC_W - 1));
    localparam logic signed [17:0] INV_GAIN = 18'sd39797; // 1/1.64676 in q16

    // atan(2^-i) in phase units, 2^24 per turn
    localparam logic signed [`PHASE_W-1:0] ATAN_TBL [0:NS-1] = '{
        2097152, 1238021, 654136, 332050, 166669, 83416, 41718,
        20860, 10430, 5215, 2608, 1304, 652, 326
    };

    logic signed [WW-1:0]       x_pipe [0:NS];
    logic signed [WW-1:0]       y_pipe [0:NS];
    logic signed [`PHASE_W-1:0] z_pipe [0:NS];
    logic signed [WW-1:0]       x_ext;
    logic                       flip;
    logic signed [WW+17:0]      prod;
    logic signed [WW+17:0]      rnd;
    sample_t                    cos_sat;

    assign x_ext = {{2{i_mag[`ADC_W-1]}}, i_mag, {FRAC{1'b0}}};
    assign flip  = i_phase[`PHASE_W-1] ^ i_phase[`PHASE_W-2];  // quadrant 2 or 3

    // ---------------------------------------------------------------------------
    // pre-rotation + micro-rotation pipeline
    // ---------------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i <= NS; i++) begin
                x_pipe[i] <= '0;
                y_pipe[i] <= '0;
                z_pipe[i] <= '0;
            end
        end else begin
            // rotate by pi into the right half-plane
            x_pipe[0] <= flip ? -x_ext : x_ext;
            y_pipe[0] <= '0;
            z_pipe[0] <= $signed(i_phase ^ {flip, {(`PHASE_W-1){1'b0}}});
            for (int i = 0; i < NS; i++) begin
                if (z_pipe[i][`PHASE_W-1]) begin       // residual negative, go cw
                    x_pipe[i+1] <= x_pipe[i] + (y_pipe[i] >>> i);
                    y_pipe[i+1] <= y_pipe[i] - (x_pipe[i] >>> i);
                    z_pipe[i+1] <= z_pipe[i] + ATAN_TBL[i];
                end else begin                         // ccw
                    x_pipe[i+1] <= x_pipe[i] - (y_pipe[i] >>> i);
                    y_pipe[i+1] <= y_pipe[i] + (x_pipe[i] >>> i);
                    z_pipe[i+1] <= z_pipe[i] - ATAN_TBL[i];
                end
            end
        end
    end

    // gain compensation, round to sample width
    assign prod = x_pipe[NS] * INV_GAIN;
    assign rnd  = (prod + RND_HALF) >>> SHIFT;

    always_comb begin
        if (rnd > SAT_MAX) begin
            cos_sat = sample_t'(SAT_MAX);
        end else if (rnd < SAT_MIN) begin
            cos_sat = sample_t'(SAT_MIN);
        end else begin
            cos_sat = rnd[`ADC_W-1:0];
        end
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_cos <= '0;
        end else begin
            o_cos <= cos_sat;      // total latency STAGES+2
        end
    end

endmodule

// ==== hdl/nco.sv ====
module nco (
    input  logic             sys_clk,
    input  logic             rst,
    input  dsp_pkg::phase_t  i_phase_inc,  // cpu tuning word
    input  dsp_pkg::sample_t i_mag,        // cpu magnitude
    output dsp_pkg::sample_t o_cos
);
    import dsp_pkg::*;

    phase_t phase_acc;

    // ---------------------------------------------------------------------------
    // phase accumulator
    // ---------------------------------------------------------------------------
    // free running, wraps mod 2^PHASE_W
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            phase_acc <= '0;
        end else begin
            phase_acc <= phase_acc + i_phase_inc;
        end
    end

    // mag * cos(phase), fixed pipeline delay
    cordic_rotator rot0 (
        .sys_clk (sys_clk),
        .rst     (rst),
        .i_mag   (i_mag),
        .i_phase (phase_acc),
        .o_cos   (o_cos)
    );

endmodule

// ==== hdl/sample_router.sv ====
`include "uberclock_macros.svh"

module sample_router (
    input  logic              sys_clk,
    input  logic              rst,
    input  logic [`ADC_W-1:0] i_adc_ch0,    // raw, offset binary
    input  logic [`ADC_W-1:0] i_adc_ch1,
    input  dsp_pkg::sample_t  i_nco,
    input  ctrl_pkg::hs_sel_e i_hs_sel,
    output dsp_pkg::sample_t  o_adc0,       // conditioned, 1 clk after pins
    output dsp_pkg::sample_t  o_adc1,
    output dsp_pkg::sample_t  o_hs_sample   // debug tap, comb from regs
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    sample_t adc0_q;
    sample_t adc1_q;

    // ---------------------------------------------------------------------------
    // adc conditioning
    // ---------------------------------------------------------------------------
    // msb flip turns offset binary into two's complement
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            adc0_q <= '0;
            adc1_q <= '0;
        end else begin
            adc0_q <= {~i_adc_ch0[`ADC_W-1], i_adc_ch0[`ADC_W-2:0]};
            adc1_q <= {~i_adc_ch1[`ADC_W-1], i_adc_ch1[`ADC_W-2:0]};
        end
    end

    assign o_adc0 = adc0_q;
    assign o_adc1 = adc1_q;

    // high-speed debug select
    always_comb begin
        case (i_hs_sel)
            HS_ADC0: o_hs_sample = adc0_q;
            HS_ADC1: o_hs_sample = adc1_q;
            default: o_hs_sample = i_nco;   // HS_NCO and code 3
        endcase
    end

endmodule

// ==== hdl/dac_formatter.sv ====
`include "uberclock_macros.svh"

module dac_formatter (
    input  logic                sys_clk,
    input  logic                rst,
    input  ctrl_pkg::dac_sel_e  i_sel_ch1,
    input  ctrl_pkg::dac_sel_e  i_sel_ch2,
    input  dsp_pkg::sample_t    i_adc0,
    input  dsp_pkg::sample_t    i_adc1,
    input  dsp_pkg::sample_t    i_nco,
    output dsp_pkg::dac_word_t  o_dac_ch1,   // offset binary, registered
    output dsp_pkg::dac_word_t  o_dac_ch2
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    // source pick, 12 -> 14 bits, then to offset binary
    function automatic dac_word_t fmt_word(dac_sel_e sel, sample_t a0, sample_t a1,
                                           sample_t nco_s);
        sample_t src;
        case (sel)
            SEL_NCO:  src = nco_s;
            SEL_ADC0: src = a0;
            SEL_ADC1: src = a1;
            default:  src = '0;       // unused codes park at mid-scale
        endcase
        // adding mid-scale mod 2^14 is the msb flip back
        return dac_word_t'({src, 2'b00}) + dac_word_t'(`DAC_MID);
    endfunction

    // ---------------------------------------------------------------------------
    // output registers
    // ---------------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            o_dac_ch1 <= dac_word_t'(`DAC_MID);
            o_dac_ch2 <= dac_word_t'(`DAC_MID);
        end else begin
            o_dac_ch1 <= fmt_word(i_sel_ch1, i_adc0, i_adc1, i_nco);
            o_dac_ch2 <= fmt_word(i_sel_ch2, i_adc0, i_adc1, i_nco);
        end
    end

endmodule

// ==== hdl/capture_buffer.sv ====
`include "uberclock_macros.svh"

module capture_buffer (
    input  logic               sys_clk,
    input  logic               rst,
    input  logic               i_arm,      // cpu level, edge starts capture
    input  dsp_pkg::sample_t   i_sample,   // high-speed tap
    input  dsp_pkg::cap_addr_t i_idx,      // readback index
    output logic               o_done,
    output dsp_pkg::cap_word_t o_data
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    cap_state_e state;
    cap_addr_t  wr_addr;
    logic       done_q;     // capture complete flag for the cpu
    logic       arm_q;
    logic       arm_edge;
    cap_word_t  mem [0:`CAP_DEPTH-1];

    // ---------------------------------------------------------------------------
    // arm edge detect
    // ---------------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            arm_q <= 1'b0;
        end else begin
            arm_q <= i_arm;
        end
    end

    assign arm_edge = i_arm & ~arm_q;

    // ---------------------------------------------------------------------------
    // capture fsm
    // ---------------------------------------------------------------------------
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state   <= CAP_IDLE;
            wr_addr <= '0;
            done_q  <= 1'b0;
        end else if (arm_edge) begin
            state   <= CAP_RUN;          // restart from any state
            wr_addr <= '0;
            done_q  <= 1'b0;             // re-arm drops done
        end else begin
            case (state)
                CAP_RUN: begin
                    if (wr_addr == cap_addr_t'(`CAP_DEPTH - 1)) begin
                        state  <= CAP_DONE;   // last slot written this clk
                        done_q <= 1'b1;
                    end else begin
                        wr_addr <= wr_addr + 1'b1;
                    end
                end
                default: state <= state;     // idle / done hold until re-arm
            endcase
        end
    end

    assign o_done = done_q;

    // sample memory, one write per clk while running
    always_ff @(posedge sys_clk) begin
        if (state == CAP_RUN) begin
            mem[wr_addr] <= cap_word_t'(i_sample);   // sign extend to 16
        end
    end

    assign o_data = mem[i_idx];      // async read for cpu

endmodule

// ==== hdl/uberclock_top.sv ====
`include "uberclock_macros.svh"

module uberclock_top (
    input  logic               sys_clk,
    input  logic               rst,
    // adc pins, offset binary
    input  logic [`ADC_W-1:0]  i_adc_ch0,
    input  logic [`ADC_W-1:0]  i_adc_ch1,
    // cpu control
    input  dsp_pkg::phase_t    i_phase_inc,
    input  dsp_pkg::sample_t   i_nco_mag,
    input  ctrl_pkg::dac_sel_e i_dac_sel_ch1,
    input  ctrl_pkg::dac_sel_e i_dac_sel_ch2,
    input  ctrl_pkg::hs_sel_e  i_hs_sel,
    input  logic               i_cap_arm,
    input  dsp_pkg::cap_addr_t i_cap_idx,
    // outputs
    output dsp_pkg::dac_word_t o_dac_ch1,
    output dsp_pkg::dac_word_t o_dac_ch2,
    output dsp_pkg::sample_t   o_hs_sample,
    output logic               o_cap_done,
    output dsp_pkg::cap_word_t o_cap_data
);
    import dsp_pkg::*;

    sample_t adc0_s;      // conditioned adc ch0
    sample_t adc1_s;
    sample_t nco_cos;
    sample_t hs_sample;   // debug tap

    // ---------------------------------------------------------------------------
    // nco
    // ---------------------------------------------------------------------------
    nco nco0 (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .i_phase_inc (i_phase_inc),
        .i_mag       (i_nco_mag),
        .o_cos       (nco_cos)
    );

    sample_router router0 (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .i_adc_ch0   (i_adc_ch0),
        .i_adc_ch1   (i_adc_ch1),
        .i_nco       (nco_cos),
        .i_hs_sel    (i_hs_sel),
        .o_adc0      (adc0_s),
        .o_adc1      (adc1_s),
        .o_hs_sample (hs_sample)
    );

    dac_formatter dacfmt0 (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .i_sel_ch1 (i_dac_sel_ch1),
        .i_sel_ch2 (i_dac_sel_ch2),
        .i_adc0    (adc0_s),
        .i_adc1    (adc1_s),
        .i_nco     (nco_cos),
        .o_dac_ch1 (o_dac_ch1),
        .o_dac_ch2 (o_dac_ch2)
    );

    // ---------------------------------------------------------------------------
    // debug capture
    // ---------------------------------------------------------------------------
    capture_buffer cap0 (
        .sys_clk  (sys_clk),
        .rst      (rst),
        .i_arm    (i_cap_arm),
        .i_sample (hs_sample),
        .i_idx    (i_cap_idx),
        .o_done   (o_cap_done),
        .o_data   (o_cap_data)
    );

    assign o_hs_sample = hs_sample;

endmodule

// ==== bench/tb_uberclock_asserts.sv ====
`include "uberclock_macros.svh"

module tb_uberclock_asserts #(
    parameter bit CAP_SIDE = 1'b1        // 1 capture fsm checks, 0 dac reset check
) (
    input logic                 sys_clk,
    input logic                 rst,
    input logic                 i_done,
    input ctrl_pkg::cap_state_e i_state,
    input logic                 i_arm_edge,
    input dsp_pkg::dac_word_t   i_dac_ch1,
    input dsp_pkg::dac_word_t   i_dac_ch2
);
    timeunit 1ns;
    timeprecision 1ps;
    import ctrl_pkg::*;

    int n_fail = 0;      // read back by the testbench at the end

    if (CAP_SIDE) begin : g_cap
        logic arm_seen;    // arm edge since done last went high

        always_ff @(posedge sys_clk or posedge rst) begin
            if (rst) begin
                arm_seen <= 1'b0;
            end else if (i_arm_edge) begin
                arm_seen <= 1'b1;          // edge wins over done
            end else if (i_done) begin
                arm_seen <= 1'b0;
            end
        end

        a_done_not_run: assert property (@(posedge sys_clk) disable iff (rst)
            !(i_done && i_state == CAP_RUN))
            else begin
                $error("capture done high while the fsm is running");
                n_fail++;
            end

        a_done_needs_arm: assert property (@(posedge sys_clk) disable iff (rst)
            $rose(i_done) |-> arm_seen)
            else begin
                $error("capture done rose with no arm edge before it");
                n_fail++;
            end
    end else begin : g_dac
        // first clock out of reset still shows mid-scale
        a_dac_mid_at_release: assert property (@(posedge sys_clk)
            $fell(rst) |-> (i_dac_ch1 == `DAC_MID && i_dac_ch2 == `DAC_MID))
            else begin
                $error("dac output not at mid-scale right after reset");
                n_fail++;
            end
    end

endmodule

// ---------------------------------------------------------------------------
// attach to the capture fsm, dac ports unused on this side
// ---------------------------------------------------------------------------
bind capture_buffer tb_uberclock_asserts #(.CAP_SIDE(1'b1)) cap_chk (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .i_done     (o_done),
    .i_state    (state),
    .i_arm_edge (arm_edge),
    .i_dac_ch1  (dsp_pkg::dac_word_t'(`DAC_MID)),
    .i_dac_ch2  (dsp_pkg::dac_word_t'(`DAC_MID))
);

// dac side only, capture ports unused
bind dac_formatter tb_uberclock_asserts #(.CAP_SIDE(1'b0)) dac_chk (
    .sys_clk    (sys_clk),
    .rst        (rst),
    .i_done     (1'b0),
    .i_state    (ctrl_pkg::CAP_IDLE),
    .i_arm_edge (1'b0),
    .i_dac_ch1  (o_dac_ch1),
    .i_dac_ch2  (o_dac_ch2)
);

// ==== bench/tb_uberclock.sv ====
`include "uberclock_macros.svh"

module tb_uberclock;
    timeunit 1ns;
    timeprecision 1ps;
    import dsp_pkg::*;
    import ctrl_pkg::*;

    typedef logic [`ADC_W-1:0] raw_t;   // adc pin code, offset binary

    logic      sys_clk;
    logic      rst;
    raw_t      i_adc_ch0;
    raw_t      i_adc_ch1;
    phase_t    i_phase_inc;
    sample_t   i_nco_mag;
    dac_sel_e  i_dac_sel_ch1;
    dac_sel_e  i_dac_sel_ch2;
    hs_sel_e   i_hs_sel;
    logic      i_cap_arm;
    cap_addr_t i_cap_idx;
    dac_word_t o_dac_ch1;
    dac_word_t o_dac_ch2;
    sample_t   o_hs_sample;
    logic      o_cap_done;
    cap_word_t o_cap_data;
    int        n_err;
    int        n_tmo;
    int        n_asrt;
    integer    seed;

    uberclock_top dut0 (.*);

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;   // 50 MHz
    end

    // ---------------------------------------------------------------------------
    // reference model and check helpers
    // ---------------------------------------------------------------------------
    // pin code minus mid-scale
    function automatic int cond_val(raw_t raw);
        return int'(raw) - (1 << (`ADC_W - 1));
    endfunction

    function automatic int dac_exp(int s);
        return (s * 4 + `DAC_MID) % (1 << `DAC_W);   // 12 -> 14 bits, back to offset
    endfunction

    task automatic check_val(string what, int got, int exp);
        if (got != exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            n_err++;
        end
    endtask

    task automatic run_until_done(input int limit, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < limit && !ok; n++) begin
            @(negedge sys_clk);
            ok = o_cap_done;
            i_adc_ch0 = i_adc_ch0 + 1'b1;     // ramp runs while waiting
        end
        if (!ok) begin
            $display("capture done did not rise within %0d cycles", limit);
            n_tmo++;
        end
    endtask

    // ---------------------------------------------------------------------------
    // directed tests
    // ---------------------------------------------------------------------------
    task automatic test_reset();
        check_val("cap done after reset", o_cap_done, 0);
        check_val("dac ch1 after reset", o_dac_ch1, `DAC_MID);
        check_val("dac ch2 after reset", o_dac_ch2, `DAC_MID);
    endtask

    task automatic test_adc_dac();
        raw_t raw0 [0:31];
        raw_t raw1 [0:31];
        for (int k = 0; k < 32; k++) begin
            raw0[k] = raw_t'($random(seed));
            raw1[k] = raw_t'($random(seed));
        end
        for (int k = 0; k < 34; k++) begin
            @(negedge sys_clk);
            if (k >= 2) begin                 // pin to dac, two clocks
                check_val("dac ch1 from adc0", o_dac_ch1, dac_exp(cond_val(raw0[k-2])));
                check_val("dac ch2 from adc1", o_dac_ch2, dac_exp(cond_val(raw1[k-2])));
            end
            if (k < 32) begin
                i_adc_ch0 = raw0[k];
                i_adc_ch1 = raw1[k];
            end
        end
        i_dac_sel_ch1 = dac_sel_e'(4'd3);     // codes with no source
        i_dac_sel_ch2 = dac_sel_e'(4'd15);
        repeat (2) @(negedge sys_clk);
        check_val("dac ch1 unused code", o_dac_ch1, `DAC_MID);
        check_val("dac ch2 unused code", o_dac_ch2, `DAC_MID);
    endtask

    task automatic test_hs_select();
        raw_t prev0;
        raw_t prev1;
        for (int k = 0; k < 16; k++) begin
            @(negedge sys_clk);
            if (k > 0) begin
                check_val("hs sample", o_hs_sample,
                          cond_val(i_hs_sel == HS_ADC1 ? prev1 : prev0));
            end
            prev0     = raw_t'($random(seed));
            prev1     = raw_t'($random(seed));
            i_adc_ch0 = prev0;
            i_adc_ch1 = prev1;
            i_hs_sel  = (k % 2 == 1) ? HS_ADC1 : HS_ADC0;
        end
    endtask

    task automatic test_nco_static();
        bit settled;
        settled = 1'b0;
        @(negedge sys_clk);
        i_nco_mag = 12'sd1000;                // phase still 0, cos = 1
        i_hs_sel  = HS_NCO;
        for (int n = 0; n < 40 && !settled; n++) begin
            @(negedge sys_clk);
            settled = (o_hs_sample >= 997 && o_hs_sample <= 1003);
        end
        if (!settled) begin
            $display("nco output did not settle near 1000 within 40 cycles");
            n_tmo++;
        end
        for (int k = 0; k < 8; k++) begin
            @(negedge sys_clk);
            if (o_hs_sample < 997 || o_hs_sample > 1003) begin
                $display("ERR %0t: nco at phase 0 gave %0d, expected 1000", $time,
                         o_hs_sample);
                n_err++;
            end
        end
    endtask

    task automatic test_nco_sweep();
        bit pos;
        bit neg;
        pos = 1'b0;
        neg = 1'b0;
        @(negedge sys_clk);
        i_nco_mag   = 12'sd1500;
        i_phase_inc = phase_t'(1 << (`PHASE_W - 6));   // 64 clocks per turn
        for (int k = 0; k < 100; k++) begin
            @(negedge sys_clk);
            if (o_hs_sample > 1503 || o_hs_sample < -1503) begin
                $display("ERR %0t: nco sample %0d out of range", $time, o_hs_sample);
                n_err++;
            end
            if (k >= 20 && k < 84) begin      // one period past the pipeline
                pos |= (o_hs_sample > 0);
                neg |= (o_hs_sample < 0);
            end
        end
        if (!(pos && neg)) begin
            $display("ERR %0t: nco sweep missed a sign in one period", $time);
            n_err++;
        end
        i_phase_inc = '0;
    endtask

    task automatic test_capture();
        bit ok;
        int prev;
        int first;
        @(negedge sys_clk);
        i_hs_sel  = HS_ADC0;
        i_adc_ch0 = raw_t'(12'h100);          // far from the 4095 -> 0 wrap
        @(negedge sys_clk);
        i_cap_arm = 1'b1;
        i_adc_ch0 = i_adc_ch0 + 1'b1;
        first     = cond_val(i_adc_ch0);      // on the tap when slot 0 is written
        run_until_done(`CAP_DEPTH + 20, ok);
        for (int i = 0; i < `CAP_DEPTH && ok; i++) begin
            @(negedge sys_clk);
            i_cap_idx = cap_addr_t'(i);
            #2;
            if (i == 0) begin
                check_val("capture word 0", o_cap_data, first);
            end
            if (i > 0 && int'(o_cap_data) - prev != 1) begin
                $display("ERR %0t: capture word %0d is %0d after %0d", $time, i,
                         o_cap_data, prev);
                n_err++;
            end
            prev = o_cap_data;
        end
    endtask

    task automatic test_rearm();
        bit ok;
        check_val("cap done before re-arm", o_cap_done, 1);
        @(negedge sys_clk);
        i_cap_arm = 1'b0;
        @(negedge sys_clk);
        i_cap_arm = 1'b1;                     // second rising edge
        @(negedge sys_clk);
        check_val("cap done after re-arm edge", o_cap_done, 0);
        run_until_done(`CAP_DEPTH + 20, ok);
    endtask

    initial begin
        seed          = 32'he4fc_c291;
        n_err         = 0;
        n_tmo         = 0;
        rst           = 1'b1;
        i_adc_ch0     = raw_t'(12'h800);      // mid-scale
        i_adc_ch1     = raw_t'(12'h800);
        i_phase_inc   = '0;
        i_nco_mag     = '0;
        i_dac_sel_ch1 = SEL_ADC0;
        i_dac_sel_ch2 = SEL_ADC1;
        i_hs_sel      = HS_ADC0;
        i_cap_arm     = 1'b0;
        i_cap_idx     = '0;
        repeat (10) @(posedge sys_clk);
        @(negedge sys_clk);
        rst = 1'b0;
        test_reset();
        test_adc_dac();
        test_hs_select();
        test_nco_static();
        test_nco_sweep();
        test_capture();
        test_rearm();
        n_asrt = dut0.cap0.cap_chk.n_fail + dut0.dacfmt0.dac_chk.n_fail;
        $display("errors %0d, timeouts %0d, assertion failures %0d", n_err, n_tmo, n_asrt);
        if (n_err == 0 && n_tmo == 0 && n_asrt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/dsp_pkg.sv
hdl/ctrl_pkg.sv
hdl/cordic_rotator.sv
hdl/nco.sv
hdl/sample_router.sv
hdl/dac_formatter.sv
hdl/capture_buffer.sv
hdl/uberclock_top.sv
bench/tb_uberclock_asserts.sv
bench/tb_uberclock.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_uberclock
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
